//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_core_tb
FILELIST = rv_core.f
OBJ_DIR  = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

//--- include/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath width
`define XLEN 64

// instruction word
`define INST_W 32

// register index and count
`define REG_ADDR_W 5
`define NUM_REGS 32

`endif

//--- rv_core.f
+incdir+include
verilog/rv_core_pkg.sv
verilog/regfile_if.sv
verilog/pipe_slice.sv
verilog/decode_stage.sv
verilog/exu_stage.sv
verilog/regfile.sv
verilog/rv_core_top.sv
testbench/rv_core_monitor.sv
testbench/rv_core_checker.sv
testbench/rv_core_tb.sv

//--- testbench/rv_core_checker.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_core_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_valid_i,
    input  logic                   wb_ready_i,
    input  logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  logic [`XLEN-1:0]       wb_data_i
);

    int fail_count = 0;

    // a stalled report stays up until taken
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_i && !wb_ready_i |=> wb_valid_i)
        else begin
            $error("writeback valid dropped before it was accepted");
            fail_count++;
        end

    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_i && !wb_ready_i |=> $stable(wb_addr_i) && $stable(wb_data_i))
        else begin
            $error("writeback address or data changed while stalled");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !wb_valid_i)
        else begin
            $error("writeback valid high right after reset");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_valid_i (wb_valid_o),
    .wb_ready_i (wb_ready_i),
    .wb_addr_i  (wb_addr_o),
    .wb_data_i  (wb_data_o)
);

//--- testbench/rv_core_monitor.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_core_monitor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_valid_i,
    input  logic                   wb_ready_i,
    input  logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  logic [`XLEN-1:0]       wb_data_i
);

    logic [`REG_ADDR_W-1:0] exp_addr_q [$];
    logic [`XLEN-1:0]       exp_data_q [$];
    int                     error_count = 0;

    task automatic push_expected(input logic [`REG_ADDR_W-1:0] addr,
                                 input logic [`XLEN-1:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    function automatic int pending_count();
        return exp_addr_q.size();
    endfunction

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        logic [`REG_ADDR_W-1:0] exp_addr;
        logic [`XLEN-1:0]       exp_data;
        if (rst_n && wb_valid_i && wb_ready_i) begin
            if (exp_addr_q.size() == 0) begin
                $display("writeback to x%0d arrived with nothing expected", wb_addr_i);
                error_count++;
            end else begin
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                if (wb_addr_i !== exp_addr) begin
                    $display("[FAIL] wb_addr_o: got 0x%h, expected 0x%h", wb_addr_i, exp_addr);
                    error_count++;
                end
                if (wb_data_i !== exp_data) begin
                    $display("[FAIL] wb_data_o: got 0x%h, expected 0x%h", wb_data_i, exp_data);
                    error_count++;
                end
            end
        end
    end

endmodule

//--- testbench/rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_core_tb;

    localparam int N_PROG  = 27;
    localparam int TIMEOUT = 100;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   inst_valid_i;
    logic                   inst_ready_o;
    logic [`INST_W-1:0]     inst_i;
    logic                   wb_valid_o;
    logic                   wb_ready_i;
    logic [`REG_ADDR_W-1:0] wb_addr_o;
    logic [`XLEN-1:0]       wb_data_o;

    logic [`INST_W-1:0]     prog_inst [N_PROG];
    logic [`REG_ADDR_W-1:0] prog_rd   [N_PROG];
    logic [`XLEN-1:0]       prog_val  [N_PROG];

    logic [15:0] lfsr = 16'd25;
    int          other_errors = 0;
    int          total_errors;

    always #10 clk = ~clk;

    rv_core_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    rv_core_monitor u_monitor (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_valid_i (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_addr_i  (wb_addr_o),
        .wb_data_i  (wb_data_o)
    );

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] op_imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic set_entry(input int i, input logic [31:0] inst,
                             input logic [4:0] rd, input logic [63:0] val);
        prog_inst[i] = inst;
        prog_rd[i]   = rd;
        prog_val[i]  = val;
    endtask

    // every source register is written earlier in the table, so reruns give the same values
    task automatic load_program();
        set_entry(0,  op_imm_word(12'hFFF, 5'd0, 3'd0, 5'd1), 5'd1, 64'hFFFFFFFFFFFFFFFF);
        set_entry(1,  op_imm_word(12'h800, 5'd0, 3'd0, 5'd2), 5'd2, 64'hFFFFFFFFFFFFF800);
        set_entry(2,  lui_word(20'h80000, 5'd3), 5'd3, 64'hFFFFFFFF80000000);
        set_entry(3,  lui_word(20'h12345, 5'd4), 5'd4, 64'h0000000012345000);
        set_entry(4,  32'h000002EF, 5'd0, 64'h0);  // jal, not supported
        set_entry(5,  op_imm_word(12'd100, 5'd0, 3'd0, 5'd5), 5'd5, 64'h64);
        set_entry(6,  op_word(7'h00, 5'd5, 5'd5, 3'd0, 5'd6), 5'd6, 64'hC8);
        set_entry(7,  op_word(7'h20, 5'd5, 5'd6, 3'd0, 5'd7), 5'd7, 64'h64);
        set_entry(8,  op_word(7'h00, 5'd6, 5'd7, 3'd7, 5'd8), 5'd8, 64'h40);
        set_entry(9,  op_word(7'h00, 5'd5, 5'd8, 3'd6, 5'd9), 5'd9, 64'h64);
        set_entry(10, op_word(7'h00, 5'd1, 5'd9, 3'd4, 5'd10), 5'd10, 64'hFFFFFFFFFFFFFF9B);
        set_entry(11, op_word(7'h20, 5'd10, 5'd0, 3'd0, 5'd11), 5'd11, 64'h65);
        set_entry(12, op_word(7'h00, 5'd5, 5'd1, 3'd2, 5'd12), 5'd12, 64'h1);
        set_entry(13, op_word(7'h00, 5'd5, 5'd1, 3'd3, 5'd13), 5'd13, 64'h0);
        set_entry(14, op_imm_word(12'hFFF, 5'd2, 3'd2, 5'd14), 5'd14, 64'h1);
        set_entry(15, op_imm_word(12'hFFF, 5'd5, 3'd3, 5'd15), 5'd15, 64'h1);
        set_entry(16, op_imm_word(12'h03F, 5'd1, 3'd1, 5'd16), 5'd16, 64'h8000000000000000);
        set_entry(17, op_imm_word(12'h03F, 5'd1, 3'd5, 5'd17), 5'd17, 64'h1);
        set_entry(18, op_imm_word(12'h404, 5'd16, 3'd5, 5'd18), 5'd18, 64'hF800000000000000);
        set_entry(19, op_imm_word(12'd35, 5'd0, 3'd0, 5'd19), 5'd19, 64'h23);
        set_entry(20, op_word(7'h00, 5'd19, 5'd5, 3'd1, 5'd20), 5'd20, 64'h0000032000000000);
        set_entry(21, op_word(7'h00, 5'd19, 5'd1, 3'd5, 5'd21), 5'd21, 64'h000000001FFFFFFF);
        set_entry(22, op_word(7'h20, 5'd19, 5'd16, 3'd5, 5'd22), 5'd22, 64'hFFFFFFFFF0000000);
        set_entry(23, op_imm_word(12'd7, 5'd5, 3'd0, 5'd0), 5'd0, 64'h6B);
        set_entry(24, op_word(7'h00, 5'd5, 5'd0, 3'd0, 5'd23), 5'd23, 64'h64);
        set_entry(25, lui_word(20'hFFFFF, 5'd0), 5'd0, 64'hFFFFFFFFFFFFF000);
        set_entry(26, op_word(7'h00, 5'd0, 5'd0, 3'd6, 5'd24), 5'd24, 64'h0);
    endtask

    // random mode adds input gaps and wb stalls
    task automatic run_table(input logic random_mode);
        int   idx;
        int   idle;
        int   cyc;
        int   first_in;
        int   first_wb;
        logic fired;
        logic gap;
        logic rdy;
        idx      = 0;
        idle     = 0;
        cyc      = 0;
        first_in = -1;
        first_wb = -1;
        while (idx < N_PROG) begin
            @(negedge clk);
            fired = inst_valid_i && inst_ready_o;
            if (wb_valid_o && wb_ready_i && first_wb < 0) begin
                first_wb = cyc;
            end
            if (fired) begin
                u_monitor.push_expected(prog_rd[idx], prog_val[idx]);
                if (first_in < 0) begin
                    first_in = cyc;
                end
                idx++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    $display("input stalled for %0d cycles at table entry %0d", idle, idx);
                    other_errors++;
                    return;
                end
            end
            @(posedge clk);
            cyc++;
            rdy = 1'b1;
            if (random_mode) begin
                take_bit(rdy);
            end
            wb_ready_i <= rdy;
            if (idx >= N_PROG) begin
                inst_valid_i <= 1'b0;
            end else if (!inst_valid_i || fired) begin
                gap = 1'b0;
                if (random_mode) begin
                    take_bit(gap);
                end
                inst_valid_i <= !gap;
                inst_i       <= prog_inst[idx];
            end
        end
        if (!random_mode && first_wb - first_in != 2) begin
            $display("first writeback came %0d cycles after the first input, not 2",
                     first_wb - first_in);
            other_errors++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        wb_ready_i   <= 1'b1;
        while (u_monitor.pending_count() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (u_monitor.pending_count() != 0) begin
            $display("%0d writebacks still missing after %0d cycles",
                     u_monitor.pending_count(), waited);
            other_errors++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        wb_ready_i   = 1'b1;
        load_program();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        run_table(1'b0);  // steady flow, forwarding every cycle
        drain();
        if (other_errors == 0) begin
            run_table(1'b1);
            drain();
        end
        repeat (3) @(posedge clk);  // catch late duplicates

        total_errors = u_monitor.error_count + other_errors + dut.u_checker.fail_count;
        $display("errors: %0d writeback mismatches, %0d other, %0d assertion failures",
                 u_monitor.error_count, other_errors, dut.u_checker.fail_count);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module decode_stage (
    input  logic                     inst_valid_i,
    output logic                     inst_ready_o,
    input  logic [`INST_W-1:0]       inst_i,

    regfile_if.reader                rf,
    input  rv_core_pkg::fwd_t        bypass_i,

    output logic                     ex_valid_o,
    input  logic                     ex_ready_i,
    output rv_core_pkg::ex_payload_t ex_data_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic                   funct7_b5;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_sh;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic                   rd_w;

    // funct3 to alu function, alt selects sub/sra
    function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        rv_core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_core_pkg::SUB : rv_core_pkg::ADD;
            3'b001:  op = rv_core_pkg::SLL;
            3'b010:  op = rv_core_pkg::SLT;
            3'b011:  op = rv_core_pkg::SLTU;
            3'b100:  op = rv_core_pkg::XOR;
            3'b101:  op = alt ? rv_core_pkg::SRA : rv_core_pkg::SRL;
            3'b110:  op = rv_core_pkg::OR;
            default: op = rv_core_pkg::AND;
        endcase
        return op;
    endfunction

    assign opcode    = inst_i[6:0];
    assign rd        = inst_i[11:7];
    assign funct3    = inst_i[14:12];
    assign rs1       = inst_i[19:15];
    assign rs2       = inst_i[24:20];
    assign funct7_b5 = inst_i[30];

    assign imm_i  = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_sh = {{(`XLEN-6){1'b0}}, inst_i[25:20]};   // shamt only
    assign imm_u  = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    // the item in the ex slice is not yet written back
    assign rs1_val = (bypass_i.en && bypass_i.addr == rs1 && rs1 != '0) ?
                     bypass_i.data : rf.rs1_data;
    assign rs2_val = (bypass_i.en && bypass_i.addr == rs2 && rs2 != '0) ?
                     bypass_i.data : rf.rs2_data;

    always_comb begin
        ex_data_o.alu_op = rv_core_pkg::ADD;
        ex_data_o.op_a   = rs1_val;
        ex_data_o.op_b   = rs2_val;
        rd_w             = 1'b0;
        case (opcode)
            rv_core_pkg::OP: begin
                ex_data_o.alu_op = alu_sel(funct3, funct7_b5);
                rd_w             = 1'b1;
            end
            rv_core_pkg::OP_IMM: begin
                // no subi, bit 30 only matters for srai
                ex_data_o.alu_op = alu_sel(funct3, funct7_b5 && funct3 == 3'b101);
                ex_data_o.op_b   = (funct3[1:0] == 2'b01) ? imm_sh : imm_i;
                rd_w             = 1'b1;
            end
            rv_core_pkg::LUI: begin
                ex_data_o.alu_op = rv_core_pkg::PASS_B;
                ex_data_o.op_b   = imm_u;
                rd_w             = 1'b1;
            end
            default: ;  // unsupported, retires as a no-op
        endcase
        ex_data_o.rd_w    = rd_w;
        ex_data_o.rd_addr = rd_w ? rd : '0;
    end

    assign ex_valid_o   = inst_valid_i;
    assign inst_ready_o = ex_ready_i;

endmodule

//--- verilog/exu_stage.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module exu_stage (
    input  logic                     ex_valid_i,
    output logic                     ex_ready_o,
    input  rv_core_pkg::ex_payload_t ex_data_i,

    output logic                     wb_valid_o,
    input  logic                     wb_ready_i,
    output rv_core_pkg::wb_payload_t wb_data_o,

    output rv_core_pkg::fwd_t        bypass_o,
    output rv_core_pkg::fwd_t        commit_o
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] rd_data;

    assign a     = ex_data_i.op_a;
    assign b     = ex_data_i.op_b;
    assign shamt = b[5:0];

    always_comb begin
        result = '0;
        case (ex_data_i.alu_op)
            rv_core_pkg::ADD:    result = a + b;
            rv_core_pkg::SUB:    result = a - b;
            rv_core_pkg::AND:    result = a & b;
            rv_core_pkg::OR:     result = a | b;
            rv_core_pkg::XOR:    result = a ^ b;
            rv_core_pkg::SLT:    result[0] = $signed(a) < $signed(b);
            rv_core_pkg::SLTU:   result[0] = a < b;
            rv_core_pkg::SLL:    result = a << shamt;
            rv_core_pkg::SRL:    result = a >> shamt;
            rv_core_pkg::SRA:    result = $unsigned($signed(a) >>> shamt);
            rv_core_pkg::PASS_B: result = b;
            default:             result = '0;
        endcase
    end

    // no-op items report zero
    assign rd_data = ex_data_i.rd_w ? result : '0;

    assign wb_valid_o        = ex_valid_i;
    assign ex_ready_o        = wb_ready_i;
    assign wb_data_o.rd_addr = ex_data_i.rd_addr;
    assign wb_data_o.rd_w    = ex_data_i.rd_w;
    assign wb_data_o.rd_data = rd_data;

    // pending result for decode
    assign bypass_o.en   = ex_valid_i && ex_data_i.rd_w;
    assign bypass_o.addr = ex_data_i.rd_addr;
    assign bypass_o.data = result;

    // write lands as the item moves into the wb slice
    assign commit_o.en   = ex_valid_i && wb_ready_i && ex_data_i.rd_w;
    assign commit_o.addr = ex_data_i.rd_addr;
    assign commit_o.data = rd_data;

endmodule

//--- verilog/pipe_slice.sv
`timescale 1ns/10ps

module pipe_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // take a new item when empty or when the held one leaves
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

//--- verilog/regfile.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module regfile (
    input  logic              clk,
    input  logic              rst_n,

    regfile_if.owner          rf,
    input  rv_core_pkg::fwd_t commit_i
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_i.en && commit_i.addr != '0) begin  // x0 stays zero
            regs[commit_i.addr] <= commit_i.data;
        end
    end

    // combinational reads
    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

endmodule

//--- verilog/regfile_if.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

interface regfile_if;

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    modport reader (
        output rs1_addr, rs2_addr,
        input  rs1_data, rs2_data
    );

    modport owner (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );

endinterface

//--- verilog/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // major opcodes still handled by decode
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLTU   = 4'd6,
        SLL    = 4'd7,
        SRL    = 4'd8,
        SRA    = 4'd9,
        PASS_B = 4'd10  // lui
    } alu_op_e;

    // decode -> execute
    typedef struct packed {
        alu_op_e                 alu_op;
        logic [`XLEN-1:0]       op_a;
        logic [`XLEN-1:0]       op_b;     // immediate already folded in
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic                    rd_w;
    } ex_payload_t;

    // execute -> writeback
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic                    rd_w;
        logic [`XLEN-1:0]       rd_data;
    } wb_payload_t;

    // register write / bypass bus
    typedef struct packed {
        logic                    en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } fwd_t;

endpackage

//--- verilog/rv_core_top.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_core_top (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   inst_valid_i,
    output logic                   inst_ready_o,
    input  logic [`INST_W-1:0]     inst_i,

    output logic                   wb_valid_o,
    input  logic                   wb_ready_i,
    output logic [`REG_ADDR_W-1:0] wb_addr_o,
    output logic [`XLEN-1:0]       wb_data_o
);

    logic                     dec_valid;
    logic                     dec_ready;
    rv_core_pkg::ex_payload_t dec_data;

    logic                     ex_valid;
    logic                     ex_ready;
    rv_core_pkg::ex_payload_t ex_data;

    logic                     exu_valid;
    logic                     exu_ready;
    rv_core_pkg::wb_payload_t exu_data;

    rv_core_pkg::wb_payload_t wb_data;
    rv_core_pkg::fwd_t        bypass;
    rv_core_pkg::fwd_t        commit;

    regfile_if rf_bus ();

    decode_stage u_decode (
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .rf           (rf_bus.reader),
        .bypass_i     (bypass),
        .ex_valid_o   (dec_valid),
        .ex_ready_i   (dec_ready),
        .ex_data_o    (dec_data)
    );

    pipe_slice #(.payload_t(rv_core_pkg::ex_payload_t)) ex_slice (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_data_i   (dec_data),
        .out_valid_o (ex_valid),
        .out_ready_i (ex_ready),
        .out_data_o  (ex_data)
    );

    exu_stage u_exu (
        .ex_valid_i (ex_valid),
        .ex_ready_o (ex_ready),
        .ex_data_i  (ex_data),
        .wb_valid_o (exu_valid),
        .wb_ready_i (exu_ready),
        .wb_data_o  (exu_data),
        .bypass_o   (bypass),
        .commit_o   (commit)
    );

    pipe_slice #(.payload_t(rv_core_pkg::wb_payload_t)) wb_slice (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (exu_valid),
        .in_ready_o  (exu_ready),
        .in_data_i   (exu_data),
        .out_valid_o (wb_valid_o),
        .out_ready_i (wb_ready_i),
        .out_data_o  (wb_data)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rf       (rf_bus.owner),
        .commit_i (commit)
    );

    assign wb_addr_o = wb_data.rd_addr;
    assign wb_data_o = wb_data.rd_data;

endmodule
